// ==== design/tf_pkg.sv ====
package tf_pkg;

	// ==========================================================================
	// byte and line widths
	// ==========================================================================
	localparam int BYTE_W             = 8;
	localparam int DEFAULT_LINE_BYTES = 64;

	// line header sits above the payload bytes
	localparam int HDR_W         = 8;
	localparam int EMPTY_W       = 6;   // low bits of the header
	localparam int HDR_FIRST_BIT = 7;
	localparam int HDR_LAST_BIT  = 6;

	// ==========================================================================
	// metadata word
	// ==========================================================================
	localparam int META_W         = 112;
	localparam int LEN_W          = 11;
	localparam int MAX_PKT_BYTES  = 2047;  // longer packets report this and overflow
	localparam int META_VALID_BIT = 111;
	localparam int META_OVF_BIT   = 110;
	localparam int META_LEN_LSB   = 96;
	localparam int META_PORT_W    = 32;    // port number in the lowest bits

	// receive side
	typedef enum logic [1:0] {
		idle    = 2'd0,
		in_pkt  = 2'd1,
		discard = 2'd2   // refused at first byte, wait for last
	} rx_state_e;

	// ==========================================================================
	// statistics
	// ==========================================================================
	localparam int PKT_CNT_W  = 8;
	localparam int BYTE_CNT_W = 16;
	localparam int META_CNT_W = 8;

endpackage

// ==== design/pkt_rx_ctrl.sv ====
`timescale 1ns/1ps

module pkt_rx_ctrl (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [tf_pkg::BYTE_W-1:0] rx_data,
	input  logic                      rx_valid,
	input  logic                      rx_last,
	input  logic                      line_alf,
	output logic                      acc_valid,
	output logic                      acc_last,
	output logic [tf_pkg::BYTE_W-1:0] acc_data
);

	import tf_pkg::*;

	rx_state_e state;
	rx_state_e state_nxt;

	// almost-full only matters on the first byte
	always_comb begin
		state_nxt = state;
		acc_valid = 1'b0;
		case (state)
			idle: begin
				if (rx_valid) begin
					if (!line_alf) begin
						acc_valid = 1'b1;
						if (!rx_last)
							state_nxt = in_pkt;
					end else if (!rx_last) begin
						state_nxt = discard;   // drop up to the last byte
					end
				end
			end
			in_pkt: begin
				acc_valid = rx_valid;        // never stalled once started
				if (rx_valid && rx_last)
					state_nxt = idle;
			end
			discard: begin
				if (rx_valid && rx_last)
					state_nxt = idle;
			end
		endcase
	end

	assign acc_last = acc_valid & rx_last;
	assign acc_data = rx_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= idle;
		else
			state <= state_nxt;
	end

	// a refused packet stays invisible downstream through its last byte
	a_refused_pkt_dropped: assert property (
		@(posedge clk) disable iff (!rst_n)
		(state == idle && rx_valid && line_alf && !rx_last)
			|=> (!acc_valid until_with (rx_valid && rx_last))
	);

endmodule

// ==== design/byte_packer.sv ====
`timescale 1ns/1ps

module byte_packer #(
	parameter int LINE_BYTES = tf_pkg::DEFAULT_LINE_BYTES
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  acc_valid,
	input  logic                                  acc_last,
	input  logic [tf_pkg::BYTE_W-1:0]             acc_data,
	output logic [LINE_BYTES*8+tf_pkg::HDR_W-1:0] line_data,
	output logic                                  line_wr
);

	import tf_pkg::*;

	localparam int IDX_W  = (LINE_BYTES > 1) ? $clog2(LINE_BYTES) : 1;
	localparam int DATA_W = LINE_BYTES * BYTE_W;

	logic [IDX_W-1:0]   idx;          // slot of the next byte
	logic               first_line;   // next line opens a packet
	logic [DATA_W-1:0]  line_reg;
	logic [DATA_W-1:0]  line_nxt;
	logic               line_done;
	logic [EMPTY_W-1:0] empty;
	logic [HDR_W-1:0]   hdr;

	// empty count has to hold LINE_BYTES-1
	if (LINE_BYTES < 1 || LINE_BYTES > 2**EMPTY_W) begin : g_size_check
		$error("byte_packer: LINE_BYTES does not fit the empty field");
	end

	// ==========================================================================
	// line assembly
	// ==========================================================================

	// byte 0 goes to the top slot, a fresh line starts from zero
	always_comb begin
		line_nxt = (idx == '0) ? '0 : line_reg;
		line_nxt[(LINE_BYTES-1-idx)*BYTE_W +: BYTE_W] = acc_data;
	end

	assign line_done = acc_valid && (acc_last || idx == IDX_W'(LINE_BYTES - 1));
	assign empty     = EMPTY_W'(LINE_BYTES - 1 - int'(idx));

	always_comb begin
		hdr                = '0;
		hdr[HDR_FIRST_BIT] = first_line;
		hdr[HDR_LAST_BIT]  = acc_last;
		hdr[EMPTY_W-1:0]   = empty;
	end

	// ==========================================================================
	// line write
	// ==========================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx        <= '0;
			first_line <= 1'b1;
			line_wr    <= 1'b0;
			line_data  <= '0;
		end else begin
			line_wr <= line_done;
			if (line_done) begin
				line_data  <= {hdr, line_nxt};
				idx        <= '0;
				first_line <= acc_last;   // after the last line a new packet begins
			end else if (acc_valid) begin
				idx <= idx + 1'b1;
			end
		end
	end

	// bytes of the line so far
	always_ff @(posedge clk) begin
		if (acc_valid && !line_done)
			line_reg <= line_nxt;
	end

	a_idx_in_line: assert property (
		@(posedge clk) disable iff (!rst_n)
		int'(idx) < LINE_BYTES
	);

endmodule

// ==== design/pkt_meta_gen.sv ====
`timescale 1ns/1ps

module pkt_meta_gen #(
	parameter int                             LINE_BYTES = tf_pkg::DEFAULT_LINE_BYTES,
	parameter logic [tf_pkg::META_PORT_W-1:0] OUT_PORT   = 1
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      acc_valid,
	input  logic                      acc_last,
	output logic [tf_pkg::META_W-1:0] meta_data,
	output logic                      meta_wr
);

	import tf_pkg::*;

	logic [LEN_W-1:0]  len_cnt;   // bytes so far, saturating
	logic              len_ovf;
	logic              at_max;
	logic [LEN_W-1:0]  len_fin;
	logic              ovf_fin;
	logic [META_W-1:0] meta_nxt;

	// a single full line must still be reported exactly
	if (LINE_BYTES < 1 || LINE_BYTES > MAX_PKT_BYTES) begin : g_len_check
		$error("pkt_meta_gen: LINE_BYTES outside the length field range");
	end

	assign at_max  = (len_cnt == LEN_W'(MAX_PKT_BYTES));
	assign len_fin = at_max ? len_cnt : len_cnt + 1'b1;
	assign ovf_fin = len_ovf | at_max;   // one more byte past the limit

	always_comb begin
		meta_nxt                        = '0;
		meta_nxt[META_VALID_BIT]        = 1'b1;
		meta_nxt[META_OVF_BIT]          = ovf_fin;
		meta_nxt[META_LEN_LSB +: LEN_W] = len_fin;
		meta_nxt[META_PORT_W-1:0]       = OUT_PORT;
	end

	// registered so it leaves together with the last line
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			len_cnt   <= '0;
			len_ovf   <= 1'b0;
			meta_wr   <= 1'b0;
			meta_data <= '0;
		end else begin
			meta_wr <= acc_valid && acc_last;
			if (acc_valid) begin
				if (acc_last) begin
					meta_data <= meta_nxt;
					len_cnt   <= '0;
					len_ovf   <= 1'b0;
				end else begin
					len_cnt <= len_fin;
					len_ovf <= ovf_fin;
				end
			end
		end
	end

	a_len_nonzero: assert property (
		@(posedge clk) disable iff (!rst_n)
		meta_wr |-> (meta_data[META_LEN_LSB +: LEN_W] != '0)
	);

endmodule

// ==== design/rx_stats.sv ====
`timescale 1ns/1ps

module rx_stats (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          rx_valid,
	input  logic                          rx_last,
	input  logic                          meta_wr,
	output logic [tf_pkg::PKT_CNT_W-1:0]  pkt_in_cnt,
	output logic [tf_pkg::BYTE_CNT_W-1:0] byte_in_cnt,
	output logic [tf_pkg::META_CNT_W-1:0] meta_cnt
);

	// ==========================================================================
	// raw input side including refused packets
	// ==========================================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pkt_in_cnt <= '0;
		else if (rx_valid && rx_last)
			pkt_in_cnt <= pkt_in_cnt + 1'b1;   // wraps
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			byte_in_cnt <= '0;
		else if (rx_valid)
			byte_in_cnt <= byte_in_cnt + 1'b1;
	end

	// one per accepted packet
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			meta_cnt <= '0;
		else if (meta_wr)
			meta_cnt <= meta_cnt + 1'b1;
	end

endmodule

// ==== design/tf_8to512.sv ====
`timescale 1ns/1ps

module tf_8to512 #(
	parameter int                             LINE_BYTES = tf_pkg::DEFAULT_LINE_BYTES,
	parameter logic [tf_pkg::META_PORT_W-1:0] OUT_PORT   = 1
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic [tf_pkg::BYTE_W-1:0]             rx_data,
	input  logic                                  rx_valid,
	input  logic                                  rx_last,
	input  logic                                  line_alf,
	output logic [LINE_BYTES*8+tf_pkg::HDR_W-1:0] line_data,
	output logic                                  line_wr,
	output logic [tf_pkg::META_W-1:0]             meta_data,
	output logic                                  meta_wr,
	output logic [tf_pkg::PKT_CNT_W-1:0]          pkt_in_cnt,
	output logic [tf_pkg::BYTE_CNT_W-1:0]         byte_in_cnt,
	output logic [tf_pkg::META_CNT_W-1:0]         meta_cnt
);

	import tf_pkg::*;

	logic              acc_valid;
	logic              acc_last;
	logic [BYTE_W-1:0] acc_data;

	pkt_rx_ctrl u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid),
		.rx_last   (rx_last),
		.line_alf  (line_alf),
		.acc_valid (acc_valid),
		.acc_last  (acc_last),
		.acc_data  (acc_data)
	);

	byte_packer #(
		.LINE_BYTES (LINE_BYTES)
	) u_packer (
		.clk       (clk),
		.rst_n     (rst_n),
		.acc_valid (acc_valid),
		.acc_last  (acc_last),
		.acc_data  (acc_data),
		.line_data (line_data),
		.line_wr   (line_wr)
	);

	pkt_meta_gen #(
		.LINE_BYTES (LINE_BYTES),
		.OUT_PORT   (OUT_PORT)
	) u_meta (
		.clk       (clk),
		.rst_n     (rst_n),
		.acc_valid (acc_valid),
		.acc_last  (acc_last),
		.meta_data (meta_data),
		.meta_wr   (meta_wr)
	);

	rx_stats u_stats (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx_valid    (rx_valid),
		.rx_last     (rx_last),
		.meta_wr     (meta_wr),
		.pkt_in_cnt  (pkt_in_cnt),
		.byte_in_cnt (byte_in_cnt),
		.meta_cnt    (meta_cnt)
	);

	// metadata goes out exactly with the packet's last line
	a_meta_with_last_line: assert property (
		@(posedge clk) disable iff (!rst_n)
		meta_wr == (line_wr && line_data[LINE_BYTES*8 + HDR_LAST_BIT])
	);

endmodule

// ==== tests/tb_ref.svh ====
`ifndef TB_REF_SVH
`define TB_REF_SVH

// ============================================================================
// stimulus source
// ============================================================================

// 16-bit galois lfsr with taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	if (s[0])
		return (s >> 1) ^ 16'hB400;
	else
		return s >> 1;
endfunction

// ============================================================================
// expected outputs
// ============================================================================

// line holding pkt_buf[start..] with its first byte in the top slot
function automatic logic [LINE_W-1:0] ref_line(input int start, input int total);
	logic [LINE_W-1:0] l;
	int                n;
	int                k;
	l = '0;
	n = total - start;
	if (n > LINE_BYTES)
		n = LINE_BYTES;
	for (k = 0; k < n; k++)
		l[(LINE_BYTES-1-k)*BYTE_W +: BYTE_W] = pkt_buf[start+k];
	l[LINE_W-1] = (start == 0);           // first line of the packet
	l[LINE_W-2] = (start + n == total);   // line that ends it
	l[LINE_BYTES*BYTE_W +: EMPTY_W] = EMPTY_W'(LINE_BYTES - n);
	return l;
endfunction

// metadata word for a packet of total bytes
function automatic logic [META_W-1:0] ref_meta(input int total);
	logic [META_W-1:0] m;
	int                len;
	m   = '0;
	len = total;
	if (len > MAX_PKT_BYTES)
		len = MAX_PKT_BYTES;   // saturates with the flag set below
	m[META_VALID_BIT]        = 1'b1;
	m[META_OVF_BIT]          = (total > MAX_PKT_BYTES);
	m[META_LEN_LSB +: LEN_W] = LEN_W'(len);
	m[META_PORT_W-1:0]       = META_PORT_W'(OUT_PORT);
	return m;
endfunction

`endif

// ==== tests/tb_tf_8to512.sv ====
`timescale 1ns/1ps

module tb_tf_8to512;

	import tf_pkg::*;

	localparam int LINE_BYTES   = DEFAULT_LINE_BYTES;
	localparam int LINE_W       = LINE_BYTES*BYTE_W + HDR_W;
	localparam int OUT_PORT     = 1;
	localparam int DRAIN_CYCLES = 200;

	logic                  clk;
	logic                  rst_n;
	logic [BYTE_W-1:0]     rx_data;
	logic                  rx_valid;
	logic                  rx_last;
	logic                  line_alf;
	logic [LINE_W-1:0]     line_data;
	logic                  line_wr;
	logic [META_W-1:0]     meta_data;
	logic                  meta_wr;
	logic [PKT_CNT_W-1:0]  pkt_in_cnt;
	logic [BYTE_CNT_W-1:0] byte_in_cnt;
	logic [META_CNT_W-1:0] meta_cnt;

	logic [BYTE_W-1:0] pkt_buf [0:4095];   // bytes of the packet being sent
	logic [LINE_W-1:0] exp_line_q [$];
	int                exp_due_q [$];      // cycle each line is due
	logic [META_W-1:0] exp_meta_q [$];
	logic [15:0]       lfsr = 16'd78;
	int                cyc = 0;
	int                raw_bytes = 0;
	int                raw_lasts = 0;
	int                acc_pkts = 0;
	string             test_name;
	int                n_pkt;

	`include "tb_ref.svh"

	tf_8to512 u_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx_data     (rx_data),
		.rx_valid    (rx_valid),
		.rx_last     (rx_last),
		.line_alf    (line_alf),
		.line_data   (line_data),
		.line_wr     (line_wr),
		.meta_data   (meta_data),
		.meta_wr     (meta_wr),
		.pkt_in_cnt  (pkt_in_cnt),
		.byte_in_cnt (byte_in_cnt),
		.meta_cnt    (meta_cnt)
	);

	always #10 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_val(input string name, input logic [LINE_W-1:0] exp,
			input logic [LINE_W-1:0] act);
		if (exp !== act)
			abort_run($sformatf("Mismatch %s expected %0h actual %0h", name, exp, act));
	endtask

	// one lfsr step per bit
	function automatic int rand_bits(input int n);
		int v;
		int i;
		v = 0;
		for (i = 0; i < n; i++) begin
			v    = (v << 1) | lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	// ==========================================================================
	// stimulus
	// ==========================================================================
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
			rx_valid = 1'b0;
			rx_last  = 1'b0;
			rx_data  = '0;
			line_alf = 1'b0;
		end
	endtask

	task automatic drive_byte(input logic [BYTE_W-1:0] d, input bit last, input bit alf);
		@(posedge clk);
		#2;
		rx_data  = d;
		rx_valid = 1'b1;
		rx_last  = last;
		line_alf = alf;
		raw_bytes++;
		if (last)
			raw_lasts++;
	endtask

	// alf_first refuses the packet, alf_mid raises the level after byte 0
	task automatic send_packet(input int len, input bit alf_first, input bit alf_mid,
			input bit gaps);
		int i;
		for (i = 0; i < len; i++)
			pkt_buf[i] = BYTE_W'(rand_bits(BYTE_W));
		for (i = 0; i < len; i++) begin
			if (gaps && i > 0 && rand_bits(2) == 0)
				idle_cycles(1 + rand_bits(2));
			drive_byte(pkt_buf[i], i == len - 1, (i == 0) ? alf_first : alf_mid);
			if (!alf_first && (i % LINE_BYTES == LINE_BYTES - 1 || i == len - 1)) begin
				exp_line_q.push_back(ref_line(i - i % LINE_BYTES, len));
				exp_due_q.push_back(cyc + 1);
			end
		end
		if (!alf_first) begin
			exp_meta_q.push_back(ref_meta(len));
			acc_pkts++;
		end
	endtask

	task automatic wait_drain();
		int t;
		t = 0;
		while ((exp_line_q.size() != 0 || exp_meta_q.size() != 0) && t < DRAIN_CYCLES) begin
			@(posedge clk);
			t++;
		end
		if (exp_line_q.size() != 0 || exp_meta_q.size() != 0)
			abort_run("timeout: expected lines or metadata words never arrived");
	endtask

	// ==========================================================================
	// compare at the falling edge
	// ==========================================================================
	always @(negedge clk) begin : compare
		logic [LINE_W-1:0] exp_l;
		if (rst_n && line_wr) begin
			if (exp_line_q.size() == 0) begin
				abort_run("a line was written while no line was expected");
			end else begin
				exp_l = exp_line_q.pop_front();
				check_val({test_name, " line"}, exp_l, line_data);
				check_val({test_name, " line timing"}, exp_due_q.pop_front(), cyc);
				check_val({test_name, " meta with last line"}, exp_l[LINE_W-2], meta_wr);
			end
		end else if (rst_n && meta_wr) begin
			abort_run("metadata was written without a line");
		end
		if (rst_n && meta_wr) begin
			if (exp_meta_q.size() == 0)
				abort_run("metadata was written while no packet was expected");
			else
				check_val({test_name, " meta"}, exp_meta_q.pop_front(), meta_data);
		end
	end

	initial begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		rx_data   = '0;
		rx_valid  = 1'b0;
		rx_last   = 1'b0;
		line_alf  = 1'b0;
		test_name = "reset";
		repeat (16) @(posedge clk);
		#2 rst_n = 1'b1;
		@(negedge clk);
		check_val("reset line_wr", 0, line_wr);
		check_val("reset meta_wr", 0, meta_wr);
		check_val("reset line_data", 0, line_data);
		check_val("reset meta_data", 0, meta_data);
		check_val("reset pkt_in_cnt", 0, pkt_in_cnt);
		check_val("reset byte_in_cnt", 0, byte_in_cnt);
		check_val("reset meta_cnt", 0, meta_cnt);

		test_name = "single_line";
		send_packet(1, 0, 0, 0);
		send_packet(64, 0, 0, 0);
		idle_cycles(3);
		wait_drain();

		test_name = "random_len";
		send_packet(128, 0, 0, 1);
		send_packet(129, 0, 0, 1);
		for (n_pkt = 0; n_pkt < 20; n_pkt++) begin
			idle_cycles(rand_bits(2));
			send_packet(1 + rand_bits(9) % 300, 0, 0, 1);
		end
		idle_cycles(2);
		wait_drain();

		test_name = "long_pkt";
		send_packet(2100, 0, 0, 0);   // length saturates
		idle_cycles(2);
		wait_drain();

		test_name = "almost_full";
		send_packet(50, 1, 0, 0);     // level drops again after the first byte
		idle_cycles(1);
		send_packet(1, 1, 0, 0);
		idle_cycles(1);
		send_packet(70, 0, 0, 1);
		idle_cycles(1);
		send_packet(150, 0, 1, 1);    // level rises mid packet
		idle_cycles(2);
		wait_drain();

		test_name = "back_to_back";
		send_packet(10, 0, 0, 0);
		send_packet(65, 0, 0, 0);
		send_packet(1, 0, 0, 0);
		send_packet(3, 0, 0, 0);
		idle_cycles(2);
		wait_drain();

		test_name = "counters";
		idle_cycles(2);
		@(negedge clk);
		check_val("pkt_in_cnt", raw_lasts % (1 << PKT_CNT_W), pkt_in_cnt);
		check_val("byte_in_cnt", raw_bytes % (1 << BYTE_CNT_W), byte_in_cnt);
		check_val("meta_cnt", acc_pkts % (1 << META_CNT_W), meta_cnt);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== tf_8to512.f ====
+incdir+tests
design/tf_pkg.sv
design/pkt_rx_ctrl.sv
design/byte_packer.sv
design/pkt_meta_gen.sv
design/rx_stats.sv
design/tf_8to512.sv
tests/tb_tf_8to512.sv
